/* compile.f */
branch_pkg.sv
branch_issue_queue.sv
branch_resolve.sv
branch_target_buffer.sv
branch_unit.sv
branch_unit_properties.sv
tb_branch_unit.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module tb_branch_unit -f compile.f

# the verdict comes from the log, so the simulator's exit status is ignored
./obj_dir/Vtb_branch_unit +verilator+error+limit+100 > sim.log 2>&1 || true
cat sim.log

if grep -q "Done: errors found" sim.log; then
  echo "simulation FAILED"
  exit 1
fi
if grep -q "Done: no errors" sim.log; then
  echo "simulation PASSED"
  exit 0
fi
echo "simulation FAILED: no result line in sim.log"
exit 1

/* tb_branch_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_branch_unit;
  import branch_pkg::*;

  localparam int NUM_REQS    = 200;
  localparam int CYCLE_LIMIT = NUM_REQS * 4 + 100;
  localparam int BURST_LEN   = 6;

  logic       CLK;
  logic       nRST;
  logic       req_valid;
  br_req_t    req;
  logic       credit_return;
  logic       result_valid;
  br_result_t result;
  addr_t      lookup_pc;
  logic       lookup_hit;
  addr_t      lookup_target;

  logic [31:0] lfsr_state;
  int          credits;
  int          sent;
  int          received;
  int          cycles = 0;
  br_req_t     sent_q [$];
  br_req_t     last_req;
  addr_t       pc_pool [4];

  // expected BTB contents, trained from the model's results
  logic     img_valid  [BTB_ENTRIES];
  btb_tag_t img_tag    [BTB_ENTRIES];
  addr_t    img_target [BTB_ENTRIES];

  branch_unit dut (
    .CLK           (CLK),
    .nRST          (nRST),
    .req_valid     (req_valid),
    .req           (req),
    .credit_return (credit_return),
    .result_valid  (result_valid),
    .result        (result),
    .lookup_pc     (lookup_pc),
    .lookup_hit    (lookup_hit),
    .lookup_target (lookup_target)
  );

  always #5 CLK = ~CLK;

  task automatic finish_with_failure();
    $display("Done: errors found");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] want);
    assert (got === want) else begin
      $display("error: %s got 0x%h expected 0x%h", name, got, want);
      finish_with_failure();
    end
  endtask

  // galois form, one step per bit handed out
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] bits;
    bits = '0;
    for (int i = 0; i < n; i++) begin
      bits = {bits[30:0], lfsr_state[0]};
      if (lfsr_state[0]) begin
        lfsr_state = (lfsr_state >> 1) ^ 32'h8020_0003;
      end else begin
        lfsr_state = lfsr_state >> 1;
      end
    end
    return bits;
  endfunction

  // edge values dominate so that sign and equality corners show up often
  function automatic word_t pick_operand();
    logic [31:0] raw;
    word_t       value;
    raw = take_bits(3);
    case (raw[2:0])
      3'd0:    value = 32'h0000_0000;
      3'd1:    value = 32'h0000_0001;
      3'd2:    value = 32'hFFFF_FFFF;
      3'd3:    value = 32'h8000_0000;
      3'd4:    value = 32'h7FFF_FFFF;
      3'd5:    value = take_bits(4);
      default: value = take_bits(32);
    endcase
    return value;
  endfunction

  function automatic br_req_t make_request(input int index);
    br_req_t     r;
    logic [31:0] raw;
    raw = take_bits(3);
    if (raw[2:0] == 3'd0 && index > 0) begin
      // repeat the last operands with the compare's signedness flipped
      r = last_req;
      if (r.br_type[2]) begin
        r.br_type = r.br_type ^ 3'b010;
      end
    end else begin
      raw = take_bits(3);
      r.br_type = raw[2:0];
      raw = take_bits(2);
      r.pc = pc_pool[raw[1:0]];
      raw = take_bits(12);
      r.imm = {{19{raw[11]}}, raw[11:0], 1'b0};
      r.reg_a = pick_operand();
      raw = take_bits(2);
      r.reg_b = (raw[1:0] == 2'd0) ? r.reg_a : pick_operand();
    end
    raw = take_bits(1);
    r.predicted_taken = raw[0];
    r.rob_tag = index[3:0];
    last_req = r;
    return r;
  endfunction

  // signed less-than: a negative operand against a non-negative one decides it
  function automatic br_result_t resolve_expected(input br_req_t r);
    br_result_t e;
    logic       eq;
    logic       ult;
    logic       slt;
    eq  = (r.reg_a == r.reg_b);
    ult = (r.reg_a < r.reg_b);
    slt = (r.reg_a[31] != r.reg_b[31]) ? r.reg_a[31] : ult;
    case (r.br_type)
      BT_BEQ:  e.taken = eq;
      BT_BNE:  e.taken = ~eq;
      BT_BLT:  e.taken = slt;
      BT_BGE:  e.taken = ~slt;
      BT_BLTU: e.taken = ult;
      BT_BGEU: e.taken = ~ult;
      default: e.taken = 1'b0;
    endcase
    e.rob_tag    = r.rob_tag;
    e.target     = r.pc + r.imm;
    e.correct_pc = e.taken ? e.target : r.pc + 32'd4;
    e.miss       = e.taken ^ r.predicted_taken;
    return e;
  endfunction

  task automatic train_image(input addr_t pc, input addr_t target, input logic taken);
    logic [3:0] idx;
    btb_tag_t   tag;
    idx = pc[5:2];
    tag = pc[31:6];
    if (taken) begin
      img_valid[idx]  = 1'b1;
      img_tag[idx]    = tag;
      img_target[idx] = target;
    end else if (img_valid[idx] && img_tag[idx] == tag) begin
      img_valid[idx] = 1'b0;
    end
  endtask

  // runs at the falling edge, before any input changes in this cycle
  task automatic observe_outputs();
    br_req_t     r;
    br_result_t  want;
    logic [3:0]  idx;
    btb_tag_t    tag;
    logic        want_hit;
    logic [31:0] raw;
    if (dut.u_props.failures != 0) begin
      $display("a protocol or timing property of the branch unit failed");
      finish_with_failure();
    end
    // lookup_pc was set one cycle ago, so the BTB has seen that write
    idx = lookup_pc[5:2];
    tag = lookup_pc[31:6];
    want_hit = img_valid[idx] && (img_tag[idx] == tag);
    check_value("lookup_hit", {31'd0, lookup_hit}, {31'd0, want_hit});
    if (want_hit) begin
      check_value("lookup_target", lookup_target, img_target[idx]);
    end
    if (credit_return) begin
      credits++;
    end
    assert (credits <= BR_QUEUE_DEPTH) else begin
      $display("more credits came back than requests were sent");
      finish_with_failure();
    end
    if (result_valid) begin
      if (sent_q.size() == 0) begin
        $display("result_valid was high with no branch outstanding");
        finish_with_failure();
      end else begin
        r = sent_q.pop_front();
        want = resolve_expected(r);
        check_value("result.rob_tag", {28'd0, result.rob_tag}, {28'd0, want.rob_tag});
        check_value("result.taken", {31'd0, result.taken}, {31'd0, want.taken});
        check_value("result.miss", {31'd0, result.miss}, {31'd0, want.miss});
        check_value("result.target", result.target, want.target);
        check_value("result.correct_pc", result.correct_pc, want.correct_pc);
        received++;
        train_image(r.pc, want.target, want.taken);
        lookup_pc = r.pc;
      end
    end else begin
      // between results, probe any pooled pc so that aliased entries are seen too
      raw = take_bits(2);
      lookup_pc = pc_pool[raw[1:0]];
    end
  endtask

  always @(posedge CLK) begin
    cycles = cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
      finish_with_failure();
    end
  end

  initial begin
    logic [31:0] raw;
    int          burst_left;
    CLK        = 1'b0;
    nRST       = 1'b1;
    req_valid  = 1'b0;
    req        = '0;
    lookup_pc  = '0;
    lfsr_state = 32'h3f72b578;
    credits    = BR_QUEUE_DEPTH;
    sent       = 0;
    received   = 0;
    burst_left = 0;
    last_req   = '0;
    // two pairs of pcs share a BTB index but carry different tags
    pc_pool = '{32'h0000_1004, 32'h0000_2004, 32'h0000_1018, 32'h0000_3018};
    for (int i = 0; i < BTB_ENTRIES; i++) begin
      img_valid[i]  = 1'b0;
      img_tag[i]    = '0;
      img_target[i] = '0;
    end
    #2 nRST = 1'b0;
    repeat (10) @(negedge CLK);
    nRST = 1'b1;

    while (sent < NUM_REQS) begin
      @(negedge CLK);
      observe_outputs();
      req_valid = 1'b0;
      if (burst_left == 0) begin
        raw = take_bits(4);
        if (raw[3:0] == 4'd0) begin
          burst_left = BURST_LEN;
        end
      end
      raw = take_bits(1);
      if (credits > 0 && (burst_left > 0 || raw[0])) begin
        req = make_request(sent);
        req_valid = 1'b1;
        sent_q.push_back(req);
        credits--;
        sent++;
        if (burst_left > 0) begin
          burst_left--;
        end
      end
    end

    // drain, then one more cycle so the last BTB write is looked up
    while (received < sent) begin
      @(negedge CLK);
      observe_outputs();
      req_valid = 1'b0;
    end
    @(negedge CLK);
    observe_outputs();

    if (credits != BR_QUEUE_DEPTH) begin
      $display("credits did not return after the drain: %0d of %0d back",
               credits, BR_QUEUE_DEPTH);
      finish_with_failure();
    end else begin
      $display("Done: no errors");
      $finish;
    end
  end

endmodule

`default_nettype wire

/* branch_unit_properties.sv */
`timescale 1ns/1ps
`default_nettype none

module branch_unit_properties (
  input wire logic CLK,
  input wire logic nRST,
  input wire logic req_valid,
  input wire logic credit_return,
  input wire logic result_valid
);
  import branch_pkg::*;

  int outstanding;
  int idle_cycles;
  int failures = 0;

  // requests whose credit has not come back yet
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      outstanding <= 0;
    end else begin
      outstanding <= outstanding + (req_valid ? 1 : 0) - (credit_return ? 1 : 0);
    end
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      idle_cycles <= 0;
    end else if (req_valid) begin
      idle_cycles <= 0;
    end else if (idle_cycles < 2 * BR_QUEUE_DEPTH) begin
      idle_cycles <= idle_cycles + 1;
    end
  end

  // a credit returned in this cycle may already be spent
  send_with_credit: assert property (@(posedge CLK) disable iff (!nRST)
    req_valid |-> (outstanding - (credit_return ? 1 : 0)) < BR_QUEUE_DEPTH)
    else begin
      $error("request sent without a credit");
      failures++;
    end

  outstanding_bounded: assert property (@(posedge CLK) disable iff (!nRST)
    outstanding <= BR_QUEUE_DEPTH)
    else begin
      $error("more requests outstanding than the queue holds");
      failures++;
    end

  // a full queue drains in BR_QUEUE_DEPTH cycles once issue stops
  credits_restored: assert property (@(posedge CLK) disable iff (!nRST)
    idle_cycles >= BR_QUEUE_DEPTH |-> outstanding == 0)
    else begin
      $error("credits not restored after a burst");
      failures++;
    end

  quiet_in_reset: assert property (@(posedge CLK)
    (!nRST || $rose(nRST)) |-> !result_valid)
    else begin
      $error("result_valid high during or right after reset");
      failures++;
    end

  credit_one_edge: assert property (@(posedge CLK) disable iff (!nRST)
    $past(req_valid && outstanding == 0) |-> credit_return)
    else begin
      $error("credit_return not one edge after acceptance into an empty queue");
      failures++;
    end

  result_two_edges: assert property (@(posedge CLK) disable iff (!nRST)
    $past(req_valid && outstanding == 0, 2) |-> result_valid && !$past(result_valid))
    else begin
      $error("result_valid not exactly two edges after acceptance into an empty queue");
      failures++;
    end

endmodule

bind branch_unit branch_unit_properties u_props (
  .CLK           (CLK),
  .nRST          (nRST),
  .req_valid     (req_valid),
  .credit_return (credit_return),
  .result_valid  (result_valid)
);

`default_nettype wire

/* branch_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module branch_unit (
  input  wire logic                CLK,
  input  wire logic                nRST,
  input  wire logic                req_valid,
  input  wire branch_pkg::br_req_t req,
  output logic                     credit_return,
  output logic                     result_valid,
  output branch_pkg::br_result_t   result,
  input  wire branch_pkg::addr_t   lookup_pc,
  output logic                     lookup_hit,
  output branch_pkg::addr_t        lookup_target
);
  import branch_pkg::*;

  logic        head_valid;
  br_req_t     head_req;
  logic        btb_update_valid;
  btb_update_t btb_update;

  branch_issue_queue u_queue (
    .CLK           (CLK),
    .nRST          (nRST),
    .req_valid     (req_valid),
    .req           (req),
    .head_valid    (head_valid),
    .head_req      (head_req),
    .credit_return (credit_return)
  );

  branch_resolve u_resolve (
    .CLK              (CLK),
    .nRST             (nRST),
    .head_valid       (head_valid),
    .head_req         (head_req),
    .result_valid     (result_valid),
    .result           (result),
    .btb_update_valid (btb_update_valid),
    .btb_update       (btb_update)
  );

  // fetch reads the BTB while resolutions train it
  branch_target_buffer u_btb (
    .CLK           (CLK),
    .nRST          (nRST),
    .lookup_pc     (lookup_pc),
    .lookup_hit    (lookup_hit),
    .lookup_target (lookup_target),
    .update_valid  (btb_update_valid),
    .update        (btb_update)
  );

endmodule

`default_nettype wire

/* branch_target_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

module branch_target_buffer (
  input  wire logic                   CLK,
  input  wire logic                   nRST,
  input  wire branch_pkg::addr_t      lookup_pc,
  output logic                        lookup_hit,
  output branch_pkg::addr_t           lookup_target,
  input  wire logic                   update_valid,
  input  wire branch_pkg::btb_update_t update
);
  import branch_pkg::*;

  logic     valid      [BTB_ENTRIES];
  btb_tag_t tag_mem    [BTB_ENTRIES];
  addr_t    target_mem [BTB_ENTRIES];

  logic [BTB_INDEX_W-1:0] lookup_index;
  btb_tag_t               lookup_tag;
  logic [BTB_INDEX_W-1:0] update_index;
  btb_tag_t               update_tag;
  logic                   update_tag_match;

  // the low two pc bits are always zero for aligned instructions
  assign lookup_index = lookup_pc[BTB_INDEX_W+1:2];
  assign lookup_tag   = lookup_pc[31 -: BTB_TAG_W];
  assign update_index = update.pc[BTB_INDEX_W+1:2];
  assign update_tag   = update.pc[31 -: BTB_TAG_W];

  assign lookup_hit    = valid[lookup_index] && (tag_mem[lookup_index] == lookup_tag);
  assign lookup_target = target_mem[lookup_index];

  assign update_tag_match = (tag_mem[update_index] == update_tag);

  // a not-taken branch only evicts its own entry, never an alias
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      for (int i = 0; i < BTB_ENTRIES; i++) begin
        valid[i] <= 1'b0;
      end
    end else if (update_valid) begin
      if (update.taken) begin
        valid[update_index] <= 1'b1;
      end else if (update_tag_match) begin
        valid[update_index] <= 1'b0;
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (update_valid && update.taken) begin
      tag_mem[update_index]    <= update_tag;
      target_mem[update_index] <= update.target;
    end
  end

endmodule

`default_nettype wire

/* branch_resolve.sv */
`timescale 1ns/1ps
`default_nettype none

module branch_resolve (
  input  wire logic                  CLK,
  input  wire logic                  nRST,
  input  wire logic                  head_valid,
  input  wire branch_pkg::br_req_t   head_req,
  output logic                       result_valid,
  output branch_pkg::br_result_t     result,
  output logic                       btb_update_valid,
  output branch_pkg::btb_update_t    btb_update
);
  import branch_pkg::*;

  logic  equal;
  logic  less_signed;
  logic  less_unsigned;
  logic  taken;
  logic  miss;
  addr_t target;
  addr_t fall_through;
  addr_t correct_pc;

  br_result_t  result_q;
  btb_update_t update_q;

  assign equal         = (head_req.reg_a == head_req.reg_b);
  assign less_signed   = ($signed(head_req.reg_a) < $signed(head_req.reg_b));
  assign less_unsigned = (head_req.reg_a < head_req.reg_b);

  // funct3 bit 0 inverts the sense of each compare pair
  always_comb begin
    case (head_req.br_type)
      BT_BEQ:  taken = equal;
      BT_BNE:  taken = !equal;
      BT_BLT:  taken = less_signed;
      BT_BGE:  taken = !less_signed;
      BT_BLTU: taken = less_unsigned;
      BT_BGEU: taken = !less_unsigned;
      default: taken = 1'b0;
    endcase
  end

  assign target       = head_req.pc + head_req.imm;
  assign fall_through = head_req.pc + 32'd4;
  assign correct_pc   = taken ? target : fall_through;
  assign miss         = (taken != head_req.predicted_taken);

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      result_valid <= 1'b0;
    end else begin
      result_valid <= head_valid;
    end
  end

  // the result and the BTB training data are captured together
  always_ff @(posedge CLK) begin
    if (head_valid) begin
      result_q.rob_tag    <= head_req.rob_tag;
      result_q.taken      <= taken;
      result_q.miss       <= miss;
      result_q.correct_pc <= correct_pc;
      result_q.target     <= target;
      update_q.pc         <= head_req.pc;
      update_q.target     <= target;
      update_q.taken      <= taken;
    end
  end

  assign result = result_q;

  // every resolved branch trains the BTB in its result cycle
  assign btb_update_valid = result_valid;
  assign btb_update       = update_q;

endmodule

`default_nettype wire

/* branch_issue_queue.sv */
`timescale 1ns/1ps
`default_nettype none

module branch_issue_queue (
  input  wire logic              CLK,
  input  wire logic              nRST,
  input  wire logic              req_valid,
  input  wire branch_pkg::br_req_t req,
  output logic                   head_valid,
  output branch_pkg::br_req_t    head_req,
  output logic                   credit_return
);
  import branch_pkg::*;

  // circular buffer of queued branches, oldest at rd_ptr
  br_req_t mem [BR_QUEUE_DEPTH];

  logic [BR_PTR_W-1:0]    wr_ptr;
  logic [BR_PTR_W-1:0]    rd_ptr;
  logic [BR_CREDIT_W-1:0] count;
  logic                   pop;

  // the resolve stage never stalls, so a valid head always leaves
  assign head_valid    = (count != '0);
  assign head_req      = mem[rd_ptr];
  assign pop           = head_valid;
  assign credit_return = pop;

  always_ff @(posedge CLK) begin
    if (req_valid) begin
      mem[wr_ptr] <= req;
    end
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      wr_ptr <= '0;
    end else if (req_valid) begin
      wr_ptr <= wr_ptr + 1'b1;
    end
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      rd_ptr <= '0;
    end else if (pop) begin
      rd_ptr <= rd_ptr + 1'b1;
    end
  end

  // the issuer's credit count keeps a push from landing on a full queue
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      count <= '0;
    end else begin
      case ({req_valid, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

`default_nettype wire

/* branch_pkg.sv */
`default_nettype none

package branch_pkg;

  typedef logic [31:0] word_t;
  typedef logic [31:0] addr_t;
  typedef logic [3:0]  rob_tag_t;
  typedef logic [2:0]  br_type_t;

  // conditional branch types, encoded as the RV32 funct3 field
  localparam br_type_t BT_BEQ  = 3'd0;
  localparam br_type_t BT_BNE  = 3'd1;
  localparam br_type_t BT_BLT  = 3'd4;
  localparam br_type_t BT_BGE  = 3'd5;
  localparam br_type_t BT_BLTU = 3'd6;
  localparam br_type_t BT_BGEU = 3'd7;

  // queue depth doubles as the issuer's starting credit count
  localparam int BR_QUEUE_DEPTH = 4;
  localparam int BR_CREDIT_W    = 3;
  localparam int BR_PTR_W       = $clog2(BR_QUEUE_DEPTH);

  // BTB index is pc[5:2] and the tag is pc[31:6]
  localparam int BTB_ENTRIES = 16;
  localparam int BTB_INDEX_W = 4;
  localparam int BTB_TAG_W   = 26;

  typedef logic [BTB_TAG_W-1:0] btb_tag_t;

  typedef struct packed {
    rob_tag_t rob_tag;
    br_type_t br_type;
    addr_t    pc;
    word_t    imm;
    word_t    reg_a;
    word_t    reg_b;
    logic     predicted_taken;
  } br_req_t;

  typedef struct packed {
    rob_tag_t rob_tag;
    logic     taken;
    logic     miss;
    addr_t    correct_pc;
    addr_t    target;
  } br_result_t;

  typedef struct packed {
    addr_t pc;
    addr_t target;
    logic  taken;
  } btb_update_t;

endpackage

`default_nettype wire
